// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= mesh_route_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// File: logic/mesh_route_top.sv
`timescale 1ns/10ps

module mesh_route_top
    import route_pkg::*;
(
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [addr_w-1:0] paddr,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    route_req_t    req;
    route_res_t    res;
    route_status_t status;
    logic          clear;

    // apb side, config and request
    route_apb_regs route_apb_regs_inst (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .status  (status),
        .req     (req),
        .clear   (clear)
    );

    route_compute route_compute_inst (
        .pclk  (pclk),
        .rst_n (rst_n),
        .req   (req),
        .res   (res)
    );

    route_result route_result_inst (
        .pclk   (pclk),
        .rst_n  (rst_n),
        .res    (res),
        .clear  (clear),
        .status (status)
    );

endmodule

// File: logic/route_apb_regs.sv
`timescale 1ns/10ps

module route_apb_regs
    import route_pkg::*;
(
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [addr_w-1:0] paddr,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  route_status_t     status,
    output route_req_t        req,
    output logic              clear
);

    logic              access;
    logic              addr_hit;
    logic              bad_access;
    logic              cfg_wr;
    logic              dest_wr;
    logic [x_w-1:0]    cur_x_q;
    logic [y_w-1:0]    cur_y_q;
    route_algo_e       algo_q;
    logic [data_w-1:0] result_word;

    assign access   = psel && penable;          // completing edge of a transfer
    assign addr_hit = (paddr == addr_config) || (paddr == addr_dest) || (paddr == addr_result);
    assign bad_access = !addr_hit || (pwrite && (paddr == addr_result));

    assign pready  = 1'b1;                      // no wait states
    assign pslverr = access && bad_access;

    assign cfg_wr  = access && pwrite && (paddr == addr_config);
    assign dest_wr = access && pwrite && (paddr == addr_dest);

    // own position and algorithm
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_x_q <= '0;
            cur_y_q <= '0;
            algo_q  <= algo_xy;
        end else if (cfg_wr) begin
            cur_x_q <= pwdata[cfg_x_lsb +: x_w];
            cur_y_q <= pwdata[cfg_y_lsb +: y_w];
            algo_q  <= route_algo_e'(pwdata[cfg_algo_lsb +: algo_w]);
        end
    end

    // request stage, dest fields double as the dest readback
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            req <= '0;
        end else begin
            req.valid <= dest_wr;               // one cycle per dest write
            if (dest_wr) begin
                req.cur_x  <= cur_x_q;
                req.cur_y  <= cur_y_q;
                req.algo   <= algo_q;
                req.dest_x <= pwdata[dest_x_lsb +: x_w];
                req.dest_y <= pwdata[dest_y_lsb +: y_w];
            end
        end
    end

    // done/error clear, one cycle after the config write
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            clear <= 1'b0;
        end else begin
            clear <= cfg_wr;
        end
    end

    always_comb begin
        result_word = '0;
        result_word[res_mask_lsb +: port_num] = status.mask;
        result_word[res_code_lsb +: code_w]   = status.code;
        result_word[res_done_bit]             = status.done;
        result_word[res_err_bit]              = status.error;
        result_word[res_cnt_lsb +: cnt_w]     = status.count;
    end

    // read mux, valid through the access phase
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (reg_addr_e'(paddr))
                addr_config: begin
                    prdata[cfg_x_lsb +: x_w]       = cur_x_q;
                    prdata[cfg_y_lsb +: y_w]       = cur_y_q;
                    prdata[cfg_algo_lsb +: algo_w] = algo_q;
                end
                addr_dest: begin
                    prdata[dest_x_lsb +: x_w] = req.dest_x;
                    prdata[dest_y_lsb +: y_w] = req.dest_y;
                end
                addr_result: prdata = result_word;
                default:     prdata = '0;       // unmapped
            endcase
        end
    end

    // master must not drop psel between setup and access
    apb_setup_to_access: assert property (@(posedge pclk) disable iff (!rst_n)
        psel && !penable |=> psel && penable);

endmodule

// File: logic/route_compute.sv
`timescale 1ns/10ps

module route_compute
    import route_pkg::*;
(
    input  logic       pclk,
    input  logic       rst_n,
    input  route_req_t req,
    output route_res_t res
);

    logic                x_plus;
    logic                x_min;
    logic                y_plus;
    logic                y_min;
    logic                same_x;
    logic                same_y;
    logic                out_of_mesh;
    port_e               x_port;
    port_e               y_port;
    logic [port_num-1:0] mask;
    logic [code_w-1:0]   code;

    // direction flags, y grows southward
    assign same_x = (req.dest_x == req.cur_x);
    assign same_y = (req.dest_y == req.cur_y);
    assign x_plus = (req.dest_x > req.cur_x);
    assign x_min  = (req.dest_x < req.cur_x);
    assign y_plus = (req.dest_y > req.cur_y);
    assign y_min  = (req.dest_y < req.cur_y);

    assign out_of_mesh = (int'(req.dest_x) >= mesh_nx) || (int'(req.dest_y) >= mesh_ny);

    assign x_port = x_plus ? port_east : port_west;
    assign y_port = y_plus ? port_south : port_north;

    // allowed output ports
    always_comb begin
        mask = '0;
        if (!out_of_mesh) begin
            if (same_x && same_y) begin
                mask[port_local] = 1'b1;
            end else if (same_x) begin
                mask[y_port] = 1'b1;            // straight north/south
            end else if (same_y) begin
                mask[x_port] = 1'b1;            // straight east/west
            end else begin
                // diagonal, algorithm decides
                case (req.algo)
                    algo_xy: begin
                        mask[x_port] = 1'b1;    // x first
                    end
                    algo_west_first: begin
                        mask[x_port] = 1'b1;
                        if (x_plus) begin
                            mask[y_port] = 1'b1;
                        end
                    end
                    algo_north_last: begin
                        mask[x_port] = 1'b1;
                        if (y_plus) begin
                            mask[port_south] = 1'b1;
                        end
                    end
                    algo_negative_first: begin
                        // east+south goes south only, west+north goes west only
                        if (!(x_plus && y_plus)) begin
                            mask[x_port] = 1'b1;
                        end
                        if (!(x_min && y_min)) begin
                            mask[y_port] = 1'b1;
                        end
                    end
                    default: mask[x_port] = 1'b1;
                endcase
            end
        end
    end

    // {x, y, a, b} port code
    assign code = out_of_mesh ? '0 : {x_plus, y_min,
                                      mask[port_east] | mask[port_west],
                                      mask[port_north] | mask[port_south]};

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res.valid <= req.valid;
            if (req.valid) begin
                res.error <= out_of_mesh;
                res.mask  <= mask;
                res.code  <= code;
            end
        end
    end

    // deterministic xy must never offer two ports
    xy_one_hot: assert property (@(posedge pclk) disable iff (!rst_n)
        res.valid && !res.error && ($past(req.algo) == algo_xy) |-> $onehot(res.mask));

    in_mesh_has_port: assert property (@(posedge pclk) disable iff (!rst_n)
        res.valid && !res.error |-> res.mask != '0);

endmodule

// File: logic/route_pkg.sv
package route_pkg;

    // mesh geometry
    localparam int mesh_nx = 4;                 // columns
    localparam int mesh_ny = 3;                 // rows
    localparam int x_w     = $clog2(mesh_nx);
    localparam int y_w     = $clog2(mesh_ny);

    localparam int port_num = 5;                // local, east, north, west, south
    localparam int code_w   = 4;                // {x, y, a, b}
    localparam int algo_w   = 2;
    localparam int cnt_w    = 8;

    // apb widths
    localparam int addr_w = 4;
    localparam int data_w = 32;

    // config register fields
    localparam int cfg_x_lsb    = 0;
    localparam int cfg_y_lsb    = 2;
    localparam int cfg_algo_lsb = 4;

    // dest register fields
    localparam int dest_x_lsb = 0;
    localparam int dest_y_lsb = 2;

    // result register fields
    localparam int res_mask_lsb = 0;
    localparam int res_code_lsb = 5;
    localparam int res_done_bit = 16;
    localparam int res_err_bit  = 17;
    localparam int res_cnt_lsb  = 24;

    // port numbers, also the bit index in the mask
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,
        port_west  = 3'd3,
        port_south = 3'd4
    } port_e;

    typedef enum logic [algo_w-1:0] {
        algo_xy             = 2'd0,
        algo_west_first     = 2'd1,
        algo_north_last     = 2'd2,
        algo_negative_first = 2'd3
    } route_algo_e;

    typedef enum logic [addr_w-1:0] {
        addr_config = 4'h0,
        addr_dest   = 4'h4,
        addr_result = 4'h8
    } reg_addr_e;

    typedef struct packed {
        logic             valid;
        logic [x_w-1:0]   cur_x;
        logic [y_w-1:0]   cur_y;
        logic [x_w-1:0]   dest_x;
        logic [y_w-1:0]   dest_y;
        route_algo_e      algo;
    } route_req_t;

    typedef struct packed {
        logic                valid;
        logic                error;             // dest outside the mesh
        logic [port_num-1:0] mask;
        logic [code_w-1:0]   code;
    } route_res_t;

    typedef struct packed {
        logic [port_num-1:0] mask;
        logic [code_w-1:0]   code;
        logic                done;
        logic                error;
        logic [cnt_w-1:0]    count;
    } route_status_t;

endpackage

// File: logic/route_result.sv
`timescale 1ns/10ps

module route_result
    import route_pkg::*;
(
    input  logic          pclk,
    input  logic          rst_n,
    input  route_res_t    res,
    input  logic          clear,
    output route_status_t status
);

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else if (res.valid) begin
            status.mask  <= res.mask;
            status.code  <= res.code;
            status.done  <= 1'b1;
            status.error <= status.error | res.error;   // sticky until clear
            status.count <= status.count + 1'b1;        // wraps at 256
        end else if (clear) begin
            // count survives a config write
            status.done  <= 1'b0;
            status.error <= 1'b0;
        end
    end

    // clear lags a config write by one stage and a result lags a dest write by two,
    // and apb transfers complete at least two edges apart
    no_clear_on_result: assert property (@(posedge pclk) disable iff (!rst_n)
        !(clear && res.valid));

endmodule

// File: sim.f
+incdir+verif
logic/route_pkg.sv
logic/route_apb_regs.sv
logic/route_compute.sv
logic/route_result.sv
logic/mesh_route_top.sv
verif/mesh_route_tb.sv

// File: verif/mesh_route_apb_tasks.svh
// apb master side, one transfer per call, starts and ends on a falling edge
task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                         input logic err_exp);
    psel       = 1'b1;
    penable    = 1'b0;
    pwrite     = 1'b1;
    paddr      = addr;
    pwdata     = data;
    exp_slverr = err_exp;
    @(negedge pclk);
    penable = 1'b1;                 // completes at the next rising edge
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic apb_read(input logic [addr_w-1:0] addr, input logic err_exp);
    psel       = 1'b1;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = addr;
    exp_slverr = err_exp;
    @(negedge pclk);
    penable = 1'b1;
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

// expected {error, mask, code} for one route request
function automatic logic [9:0] expected_route(
    input logic [x_w-1:0] cx,
    input logic [y_w-1:0] cy,
    input logic [x_w-1:0] dx,
    input logic [y_w-1:0] dy,
    input route_algo_e    algo
);
    logic                east;
    logic                west;
    logic                north;
    logic                south;
    logic                err;
    logic [port_num-1:0] m;
    logic [code_w-1:0]   c;
    east  = dx > cx;
    west  = dx < cx;
    north = dy < cy;                // rows count southward
    south = dy > cy;
    err   = (int'(dx) >= mesh_nx) || (int'(dy) >= mesh_ny);
    m     = '0;
    c     = '0;
    if (!err) begin
        if (!(east || west)) begin
            m[port_local] = !(north || south);
            m[port_north] = north;
            m[port_south] = south;
        end else if (!(north || south)) begin
            m[port_east] = east;
            m[port_west] = west;
        end else begin
            case (algo)
                algo_xy: begin
                    m[port_east] = east;
                    m[port_west] = west;
                end
                algo_west_first: begin
                    m[port_west]  = west;
                    m[port_east]  = east;
                    m[port_north] = east && north;
                    m[port_south] = east && south;
                end
                algo_north_last: begin
                    m[port_east]  = east;
                    m[port_west]  = west;
                    m[port_south] = south;  // north only once x is done
                end
                default: begin
                    // negative first
                    m[port_west]  = west;
                    m[port_east]  = east && north;
                    m[port_north] = east && north;
                    m[port_south] = south;
                end
            endcase
        end
        c = {east, north, m[port_east] | m[port_west], m[port_north] | m[port_south]};
    end
    return {err, m, c};
endfunction

// File: verif/mesh_route_tb.sv
`timescale 1ns/10ps

module mesh_route_tb
    import route_pkg::*;
();

    localparam int n_pos         = mesh_nx * mesh_ny;
    localparam int n_rand        = 40;  // routes per adaptive algorithm
    localparam int n_burst       = 24;
    localparam int num_transfers = 1 + n_pos * (1 + 2 * n_pos) + 9 * n_rand + 7
                                   + (n_burst + 1) + 7;
    localparam int watchdog_cycles = 8 + num_transfers * 4 + 100;

    logic              pclk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // reference model of the status word
    logic [port_num-1:0] model_mask;
    logic [code_w-1:0]   model_code;
    logic                model_done;
    logic                model_err;
    logic [cnt_w-1:0]    model_count;
    logic [x_w-1:0]      cfg_x;
    logic [y_w-1:0]      cfg_y;
    route_algo_e         cfg_algo;
    logic [data_w-1:0]   model_cfg_word;
    logic [data_w-1:0]   model_dest_word;

    logic [data_w-1:0] exp_word;
    logic              exp_slverr;
    logic              chk_result;
    logic              chk_word;
    logic              xfer_done;
    logic              rd_done;
    int                seed;

    `include "mesh_route_apb_tasks.svh"

    mesh_route_top mesh_route_top_inst (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge pclk);
        $display("timeout: no end of test after %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, exp_val, got_val);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    assign xfer_done = psel && penable;
    assign rd_done   = xfer_done && !pwrite;

    slverr_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        pslverr == (xfer_done && exp_slverr))
        else report_mismatch("pslverr", 32'(xfer_done && exp_slverr), 32'(pslverr));

    pready_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        xfer_done |-> pready)
        else report_mismatch("pready", 32'd1, 32'(pready));

    mask_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_done && chk_result |-> prdata[res_mask_lsb +: port_num] == model_mask)
        else report_mismatch("result.mask", 32'(model_mask),
                             32'(prdata[res_mask_lsb +: port_num]));

    code_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_done && chk_result |-> prdata[res_code_lsb +: code_w] == model_code)
        else report_mismatch("result.code", 32'(model_code),
                             32'(prdata[res_code_lsb +: code_w]));

    done_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_done && chk_result |-> prdata[res_done_bit] == model_done)
        else report_mismatch("result.done", 32'(model_done), 32'(prdata[res_done_bit]));

    error_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_done && chk_result |-> prdata[res_err_bit] == model_err)
        else report_mismatch("result.error", 32'(model_err), 32'(prdata[res_err_bit]));

    count_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_done && chk_result |-> prdata[res_cnt_lsb +: cnt_w] == model_count)
        else report_mismatch("result.count", 32'(model_count),
                             32'(prdata[res_cnt_lsb +: cnt_w]));

    word_chk: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_done && chk_word |-> prdata == exp_word)
        else report_mismatch("prdata", exp_word, prdata);

    task automatic write_config(input logic [x_w-1:0] x, input logic [y_w-1:0] y,
                                input route_algo_e algo);
        logic [data_w-1:0] word;
        word = '0;
        word[cfg_x_lsb +: x_w]       = x;
        word[cfg_y_lsb +: y_w]       = y;
        word[cfg_algo_lsb +: algo_w] = algo;
        apb_write(addr_config, word, 1'b0);
        cfg_x          = x;
        cfg_y          = y;
        cfg_algo       = algo;
        model_cfg_word = word;
        model_done     = 1'b0;          // count is kept
        model_err      = 1'b0;
    endtask

    task automatic route_to(input logic [x_w-1:0] dx, input logic [y_w-1:0] dy);
        logic [data_w-1:0] word;
        logic [9:0]        exp;
        word = '0;
        word[dest_x_lsb +: x_w] = dx;
        word[dest_y_lsb +: y_w] = dy;
        exp = expected_route(cfg_x, cfg_y, dx, dy, cfg_algo);
        apb_write(addr_dest, word, 1'b0);
        model_dest_word = word;
        model_err       = model_err | exp[9];   // sticky
        model_mask      = exp[8:4];
        model_code      = exp[3:0];
        model_done      = 1'b1;
        model_count     = model_count + 1'b1;
    endtask

    task automatic check_result();
        @(negedge pclk);                // one idle cycle so the pipeline catches up
        chk_result = 1'b1;
        apb_read(addr_result, 1'b0);
        chk_result = 1'b0;
    endtask

    task automatic check_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp);
        @(negedge pclk);
        exp_word = exp;
        chk_word = 1'b1;
        apb_read(addr, 1'b0);
        chk_word = 1'b0;
    endtask

    task automatic run_adaptive(input route_algo_e algo);
        int r;
        for (int i = 0; i < n_rand; i++) begin
            r = $random(seed);
            write_config(r[1:0], r[3:2] % 2'd3, algo);
            route_to(r[5:4], r[7:6] % 2'd3);
            check_result();
        end
    endtask

    initial begin
        int r;
        seed            = 32'he010ee6f;
        rst_n           = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        exp_word        = '0;
        exp_slverr      = 1'b0;
        chk_result      = 1'b0;
        chk_word        = 1'b0;
        model_mask      = '0;
        model_code      = '0;
        model_done      = 1'b0;
        model_err       = 1'b0;
        model_count     = '0;
        cfg_x           = '0;
        cfg_y           = '0;
        cfg_algo        = algo_xy;
        model_cfg_word  = '0;
        model_dest_word = '0;
        repeat (8) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;

        check_result();                 // all zero out of reset

        // xy over every position and destination
        for (int cx = 0; cx < mesh_nx; cx++) begin
            for (int cy = 0; cy < mesh_ny; cy++) begin
                write_config(x_w'(cx), y_w'(cy), algo_xy);
                for (int dx = 0; dx < mesh_nx; dx++) begin
                    for (int dy = 0; dy < mesh_ny; dy++) begin
                        route_to(x_w'(dx), y_w'(dy));
                        check_result();
                    end
                end
            end
        end

        run_adaptive(algo_west_first);
        run_adaptive(algo_north_last);
        run_adaptive(algo_negative_first);

        // row 3 is off the mesh
        write_config(2'd1, 2'd1, algo_west_first);
        route_to(2'd2, 2'd3);
        check_result();
        route_to(2'd0, 2'd0);
        check_result();
        write_config(2'd1, 2'd1, algo_xy);
        check_result();

        // back-to-back dest writes overlap in the pipeline
        for (int i = 0; i < n_burst; i++) begin
            r = $random(seed);
            route_to(r[1:0], r[3:2]);
        end
        check_result();

        // bad accesses leave every register alone
        apb_write(4'hc, 32'hffff_ffff, 1'b1);
        apb_write(4'h5, 32'hffff_ffff, 1'b1);
        apb_write(addr_result, 32'hffff_ffff, 1'b1);
        apb_read(4'hc, 1'b1);
        check_word(addr_config, model_cfg_word);
        check_word(addr_dest, model_dest_word);
        check_result();

        $display("=== PASS ===");
        $finish;
    end

endmodule
